/* Bender.yml */
package:
  name: lsu_load

sources:
  - include_dirs:
      - hw
    files:
      - hw/lsu_pkg.sv
      - hw/lsu_scratchpad.sv
      - hw/lsu_csr.sv
      - hw/axi_read_intf.sv
      - hw/lsu_load_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/tb_clkgen.sv
      - verif/axi_mem_model.sv
      - verif/tb_lsu_load.sv

/* flist.f */
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_scratchpad.sv
hw/lsu_csr.sv
hw/axi_read_intf.sv
hw/lsu_load_top.sv
verif/tb_clkgen.sv
verif/axi_mem_model.sv
verif/tb_lsu_load.sv

/* hw/axi_read_intf.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module axi_read_intf (
    input  logic                       clk,
    input  logic                       rst_n,
    input  lsu_pkg::ld_req_t           ld_req,
    input  logic                       req_valid,
    output logic                       req_ready,
    output logic [`LSU_AXI_ID_W-1:0]   arid,
    output logic [31:0]                araddr,
    output logic [7:0]                 arlen,
    output logic [2:0]                 arsize,
    output logic [1:0]                 arburst,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [`LSU_AXI_ID_W-1:0]   rid,
    input  logic [63:0]                rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rlast,
    input  logic                       rvalid,
    output logic                       rready,
    output lsu_pkg::spad_wr_t          spad_wr,
    output logic                       ld_done,
    output logic                       ld_err
);

    localparam int IDW   = `LSU_AXI_ID_W;
    localparam int NSLOT = `LSU_MAX_OUTST;
    localparam int AW    = `LSU_SPAD_AW;

    lsu_pkg::ld_state_e  state;
    lsu_pkg::ld_req_t    req_q;
    logic [7:0]          issue_cnt;
    logic [7:0]          rlast_cnt;
    logic [AW-1:0]       base_nxt;
    logic [IDW-1:0]      arid_inc;
    logic                req_fire;
    logic                ar_fire;
    logic                r_fire;
    logic                last_ar;
    logic                last_r;
    logic                err_acc;
    logic                final_q;

    // per-id slot table
    logic [NSLOT-1:0]    slot_vld;
    logic [AW-1:0]       slot_base [NSLOT];
    logic [7:0]          slot_beat [NSLOT];

    logic                wr_en_q;
    logic [AW-1:0]       wr_addr_q;
    logic [63:0]         wr_data_q;

    assign req_ready = (state == lsu_pkg::LD_IDLE);
    assign req_fire  = req_valid & req_ready;
    assign ar_fire   = arvalid & arready;
    assign r_fire    = rvalid & rready;
    assign arid_inc  = arid + IDW'(1);
    assign last_ar   = (issue_cnt + 8'd1 == req_q.count);
    assign last_r    = r_fire & rlast & (rlast_cnt + 8'd1 == req_q.count);

    // incr bursts of 8-byte beats only
    assign arlen   = req_q.len;
    assign arsize  = 3'd3;
    assign arburst = 2'b01;
    assign rready  = 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= lsu_pkg::LD_IDLE;
            arvalid   <= 1'b0;
            arid      <= '0;
            issue_cnt <= '0;
        end else begin
            case (state)
                lsu_pkg::LD_IDLE: begin
                    if (req_fire) begin
                        state     <= lsu_pkg::LD_ISSUE;
                        arvalid   <= 1'b1;
                        arid      <= '0;
                        issue_cnt <= '0;
                    end
                end
                lsu_pkg::LD_ISSUE: begin
                    if (ar_fire) begin
                        issue_cnt <= issue_cnt + 8'd1;
                        arid      <= arid_inc;
                        if (last_ar) begin
                            arvalid <= 1'b0;
                            state   <= lsu_pkg::LD_DRAIN;
                        end else begin
                            // next id busy means 16 bursts in flight
                            arvalid <= ~slot_vld[arid_inc];
                        end
                    end else if (!arvalid) begin
                        arvalid <= ~slot_vld[arid];
                    end
                end
                lsu_pkg::LD_DRAIN: begin
                    if (final_q) begin
                        state <= lsu_pkg::LD_IDLE;
                    end
                end
                default: state <= lsu_pkg::LD_IDLE;
            endcase
        end
    end

    // address and scratchpad base steppers
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q    <= ld_req;
            araddr   <= ld_req.dram_addr;
            base_nxt <= ld_req.sram_addr;
        end else if (ar_fire) begin
            araddr   <= araddr + req_q.stride;
            base_nxt <= base_nxt + AW'(req_q.len) + AW'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_vld <= '0;
        end else begin
            if (r_fire && rlast) begin
                slot_vld[rid] <= 1'b0;
            end
            if (ar_fire) begin
                slot_vld[arid] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire) begin
            slot_beat[rid] <= slot_beat[rid] + 8'd1;
        end
        if (ar_fire) begin
            slot_base[arid] <= base_nxt;
            slot_beat[arid] <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en_q   <= 1'b0;
            rlast_cnt <= '0;
            err_acc   <= 1'b0;
            final_q   <= 1'b0;
            ld_done   <= 1'b0;
            ld_err    <= 1'b0;
        end else begin
            wr_en_q <= r_fire;
            final_q <= last_r;
            // done trails the final scratchpad write by one cycle
            ld_done <= final_q;
            ld_err  <= final_q & err_acc;
            if (req_fire) begin
                rlast_cnt <= '0;
                err_acc   <= 1'b0;
            end else if (r_fire) begin
                if (rlast) begin
                    rlast_cnt <= rlast_cnt + 8'd1;
                end
                if (rresp != lsu_pkg::RESP_OKAY) begin
                    err_acc <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire) begin
            wr_addr_q <= slot_base[rid] + AW'(slot_beat[rid]);
            wr_data_q <= rdata;
        end
    end

    assign spad_wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

    ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    r_slot_live: assert property (@(posedge clk) disable iff (!rst_n)
        r_fire |-> slot_vld[rid])
        else $error("R beat for id %0h with no burst outstanding", rid);

endmodule

`default_nettype wire

/* hw/lsu_csr.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_csr (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [`LSU_WB_ADR_W-1:0]   wb_adr,
    input  logic [31:0]                wb_dat_w,
    output logic [31:0]                wb_dat_r,
    output logic                       wb_ack,
    output lsu_pkg::ld_req_t           ld_req,
    output logic                       req_valid,
    input  logic                       req_ready,
    input  logic                       ld_done,
    input  logic                       ld_err,
    output logic                       spad_rd_en,
    output logic [`LSU_SPAD_AW-1:0]    spad_rd_addr,
    input  logic [63:0]                spad_rd_data
);

    localparam int AW  = `LSU_SPAD_AW;
    localparam int WIN = `LSU_WB_ADR_W - 1;

    lsu_pkg::ld_req_t   cfg_q;
    lsu_pkg::csr_reg_e  reg_off;
    logic               acc;
    logic               reg_hit;
    logic               start;
    logic               busy;
    logic               done_q;
    logic               err_q;
    logic               win_q;
    logic               half_q;
    logic [31:0]        reg_rdata;
    logic [31:0]        rdata_q;

    // new access only while no ack is pending
    assign acc     = wb_cyc & wb_stb & ~wb_ack;
    assign reg_off = lsu_pkg::csr_reg_e'(wb_adr[3:0]);
    assign reg_hit = ~wb_adr[WIN] & (wb_adr[WIN-1:4] == '0);
    assign start   = acc & wb_we & reg_hit & (reg_off == lsu_pkg::REG_CTRL)
                     & wb_dat_w[0] & ~busy;

    // window word 2k/2k+1 -> scratchpad word k
    assign spad_rd_en   = acc & wb_adr[WIN] & ~wb_we;
    assign spad_rd_addr = wb_adr[AW:1];

    assign ld_req = cfg_q;

    always_comb begin
        case (reg_off)
            lsu_pkg::REG_STATUS:    reg_rdata = {29'd0, err_q, done_q, busy};
            lsu_pkg::REG_DRAM_BASE: reg_rdata = cfg_q.dram_addr;
            lsu_pkg::REG_STRIDE:    reg_rdata = cfg_q.stride;
            lsu_pkg::REG_SRAM_BASE: reg_rdata = 32'(cfg_q.sram_addr);
            lsu_pkg::REG_BURST_CFG: reg_rdata = {16'd0, cfg_q.count, cfg_q.len};
            default:                reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_q     <= '0;
            wb_ack    <= 1'b0;
            win_q     <= 1'b0;
            req_valid <= 1'b0;
            busy      <= 1'b0;
            done_q    <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            wb_ack    <= acc;
            win_q     <= acc & wb_adr[WIN];
            req_valid <= start;
            if (acc && wb_we && reg_hit) begin
                case (reg_off)
                    lsu_pkg::REG_DRAM_BASE: cfg_q.dram_addr <= wb_dat_w;
                    lsu_pkg::REG_STRIDE:    cfg_q.stride    <= wb_dat_w;
                    lsu_pkg::REG_SRAM_BASE: cfg_q.sram_addr <= wb_dat_w[AW-1:0];
                    lsu_pkg::REG_BURST_CFG: begin
                        cfg_q.len   <= wb_dat_w[7:0];
                        cfg_q.count <= wb_dat_w[15:8];
                    end
                    default: ;
                endcase
            end
            // sticky status, cleared by the next start
            if (start) begin
                busy   <= 1'b1;
                done_q <= 1'b0;
                err_q  <= 1'b0;
            end else if (busy && ld_done) begin
                busy   <= 1'b0;
                done_q <= 1'b1;
                err_q  <= ld_err;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            rdata_q <= reg_hit ? reg_rdata : '0;
            half_q  <= wb_adr[0];
        end
    end

    // scratchpad data lands in the ack cycle
    assign wb_dat_r = win_q ? (half_q ? spad_rd_data[63:32] : spad_rd_data[31:0]) : rdata_q;

    req_only_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> req_ready)
        else $error("load request issued while read interface busy");

endmodule

`default_nettype wire

/* hw/lsu_load_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_load_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [`LSU_WB_ADR_W-1:0]   wb_adr,
    input  logic [31:0]                wb_dat_w,
    output logic [31:0]                wb_dat_r,
    output logic                       wb_ack,
    output logic [`LSU_AXI_ID_W-1:0]   arid,
    output logic [31:0]                araddr,
    output logic [7:0]                 arlen,
    output logic [2:0]                 arsize,
    output logic [1:0]                 arburst,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [`LSU_AXI_ID_W-1:0]   rid,
    input  logic [63:0]                rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rlast,
    input  logic                       rvalid,
    output logic                       rready
);

    lsu_pkg::ld_req_t           ld_req;
    lsu_pkg::spad_wr_t          spad_wr;
    logic                       req_valid;
    logic                       req_ready;
    logic                       ld_done;
    logic                       ld_err;
    logic                       spad_rd_en;
    logic [`LSU_SPAD_AW-1:0]    spad_rd_addr;
    logic [63:0]                spad_rd_data;

    lsu_csr u_lsu_csr (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .ld_req       (ld_req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .ld_done      (ld_done),
        .ld_err       (ld_err),
        .spad_rd_en   (spad_rd_en),
        .spad_rd_addr (spad_rd_addr),
        .spad_rd_data (spad_rd_data)
    );

    axi_read_intf u_axi_read_intf (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld_req    (ld_req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .arid      (arid),
        .araddr    (araddr),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .arvalid   (arvalid),
        .arready   (arready),
        .rid       (rid),
        .rdata     (rdata),
        .rresp     (rresp),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready),
        .spad_wr   (spad_wr),
        .ld_done   (ld_done),
        .ld_err    (ld_err)
    );

    lsu_scratchpad u_lsu_scratchpad (
        .clk     (clk),
        .spad_wr (spad_wr),
        .rd_en   (spad_rd_en),
        .rd_addr (spad_rd_addr),
        .rd_data (spad_rd_data)
    );

endmodule

`default_nettype wire

/* hw/lsu_pkg.sv */
`default_nettype none
`include "lsu_settings.svh"

package lsu_pkg;

    // one load as programmed by the host
    typedef struct packed {
        logic [31:0]               dram_addr;
        logic [31:0]               stride;
        logic [`LSU_SPAD_AW-1:0]   sram_addr;
        logic [7:0]                len;
        logic [7:0]                count;
    } ld_req_t;

    typedef struct packed {
        logic                      en;
        logic [`LSU_SPAD_AW-1:0]   addr;
        logic [63:0]               data;
    } spad_wr_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // word offsets in the register space
    typedef enum logic [3:0] {
        REG_CTRL      = 4'd0,
        REG_STATUS    = 4'd1,
        REG_DRAM_BASE = 4'd2,
        REG_STRIDE    = 4'd3,
        REG_SRAM_BASE = 4'd4,
        REG_BURST_CFG = 4'd5
    } csr_reg_e;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_ISSUE,
        LD_DRAIN
    } ld_state_e;

endpackage

`default_nettype wire

/* hw/lsu_scratchpad.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_scratchpad (
    input  logic                       clk,
    input  lsu_pkg::spad_wr_t          spad_wr,
    input  logic                       rd_en,
    input  logic [`LSU_SPAD_AW-1:0]    rd_addr,
    output logic [63:0]                rd_data
);

    logic [63:0] mem [`LSU_SPAD_DEPTH];

    // write port, fed by the R path
    always_ff @(posedge clk) begin
        if (spad_wr.en) begin
            mem[spad_wr.addr] <= spad_wr.data;
        end
    end

    // read port, one cycle latency
    // a read colliding with a write returns the old word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hw/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// axi id width, ids roll over per burst
`define LSU_AXI_ID_W 4

// outstanding burst limit, one slot per id value
`define LSU_MAX_OUTST 16

// scratchpad geometry in 64-bit words
`define LSU_SPAD_DEPTH 256
`define LSU_SPAD_AW 8

// wishbone word address, msb selects the scratchpad window
`define LSU_WB_ADR_W 11

`endif

/* verif/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module axi_mem_model (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`LSU_AXI_ID_W-1:0]   arid,
    input  logic [31:0]                araddr,
    input  logic [7:0]                 arlen,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [`LSU_AXI_ID_W-1:0]   rid,
    output logic [63:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rlast,
    output logic                       rvalid,
    input  logic                       rready
);

    typedef struct packed {
        logic [`LSU_AXI_ID_W-1:0]  id;
        logic [31:0]               addr;
        logic [7:0]                len;
    } ar_rec_t;

    ar_rec_t      pend [$];
    int           beat = 0;
    logic [15:0]  lfsr_q = 16'd4;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per stall bit
    task automatic take_bit(output logic b);
        lfsr_q = lfsr_next(lfsr_q);
        b = lfsr_q[0];
    endtask

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rid     = '0;
        rdata   = '0;
        rresp   = 2'b00;
    end

    always @(posedge clk) begin
        ar_rec_t      cur;
        logic [31:0]  baddr;
        logic         go;
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            pend.delete();
            beat = 0;
        end else begin
            if (arvalid && arready) begin
                pend.push_back('{id: arid, addr: araddr, len: arlen});
            end
            take_bit(go);
            arready <= go;
            if (rvalid && rready) begin
                if (rlast) begin
                    void'(pend.pop_front());
                    beat = 0;
                end else begin
                    beat = beat + 1;
                end
            end
            // a beat not yet taken stays on the bus
            if (!(rvalid && !rready)) begin
                go = 1'b0;
                if (pend.size() != 0) begin
                    take_bit(go);
                end
                if (go) begin
                    cur   = pend[0];
                    baddr = cur.addr + 32'(beat) * 32'd8;
                    rid   <= cur.id;
                    rdata <= {~baddr, baddr};
                    rresp <= baddr[31] ? lsu_pkg::RESP_SLVERR : lsu_pkg::RESP_OKAY;
                    rlast <= (beat == int'(cur.len));
                    rvalid <= 1'b1;
                end else begin
                    rvalid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* verif/tb_lsu_load.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module tb_lsu_load;

    localparam int NROWS     = 5;
    // per beat, register readback of both halves included
    localparam int BEAT_NS   = 40 * 8;
    localparam int MARGIN_NS = 2000 * 8;

    typedef struct packed {
        logic [31:0]               dram_addr;
        logic [31:0]               stride;
        logic [`LSU_SPAD_AW-1:0]   sram_addr;
        logic [7:0]                len;
        logic [7:0]                count;
        logic                      exp_err;
        logic                      restart;
    } row_t;

    // dram base, stride, sram base, len, count, error expected, restart while busy
    row_t rows [NROWS] = '{
        '{32'h0000_1000, 32'h0000_0000, 8'h00, 8'd7, 8'd1,  1'b0, 1'b0},
        '{32'h0002_0000, 32'h0000_0100, 8'h10, 8'd3, 8'd20, 1'b0, 1'b0},
        '{32'h8000_4000, 32'h0000_0040, 8'h60, 8'd1, 8'd4,  1'b1, 1'b0},
        '{32'h0000_3000, 32'h0000_0020, 8'h68, 8'd3, 8'd2,  1'b0, 1'b0},
        '{32'h0010_0000, 32'h0000_0080, 8'h80, 8'd7, 8'd12, 1'b0, 1'b1}
    };

    logic                       clk;
    logic                       rst_n;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [`LSU_WB_ADR_W-1:0]   wb_adr;
    logic [31:0]                wb_dat_w;
    logic [31:0]                wb_dat_r;
    logic                       wb_ack;
    logic [`LSU_AXI_ID_W-1:0]   arid;
    logic [31:0]                araddr;
    logic [7:0]                 arlen;
    logic [2:0]                 arsize;
    logic [1:0]                 arburst;
    logic                       arvalid;
    logic                       arready;
    logic [`LSU_AXI_ID_W-1:0]   rid;
    logic [63:0]                rdata;
    logic [1:0]                 rresp;
    logic                       rlast;
    logic                       rvalid;
    logic                       rready;

    int    err_count = 0;
    int    ar_num = 0;
    int    rl_num = 0;
    row_t  cur_row = '0;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lsu_load_top u_lsu_load_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .arid     (arid),
        .araddr   (araddr),
        .arlen    (arlen),
        .arsize   (arsize),
        .arburst  (arburst),
        .arvalid  (arvalid),
        .arready  (arready),
        .rid      (rid),
        .rdata    (rdata),
        .rresp    (rresp),
        .rlast    (rlast),
        .rvalid   (rvalid),
        .rready   (rready)
    );

    axi_mem_model u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        err_count++;
        $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic report_fail(input string msg);
        err_count++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic wb_access(input logic we, input logic [`LSU_WB_ADR_W-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        @(posedge clk);
        while (!wb_ack && waited < 16) begin
            waited++;
            @(posedge clk);
        end
        if (!wb_ack) report_fail($sformatf("no wishbone ack for address 0x%0h", adr));
        rdat = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [`LSU_WB_ADR_W-1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [`LSU_WB_ADR_W-1:0] adr, output logic [31:0] dat);
        wb_access(1'b0, adr, 32'h0, dat);
    endtask

    // window word 2k holds bits 31:0 of scratchpad word k
    function automatic logic [`LSU_WB_ADR_W-1:0] win_adr(
        input logic [`LSU_SPAD_AW-1:0] word, input logic hi);
        win_adr = '0;
        win_adr[`LSU_WB_ADR_W-1] = 1'b1;
        win_adr[`LSU_SPAD_AW:1]  = word;
        win_adr[0]               = hi;
    endfunction

    // AR order, id rollover and outstanding limit
    always @(posedge clk) begin
        logic [31:0] exp_addr;
        int          exp_id;
        if (rst_n) begin
            if (rready !== 1'b1) report_mismatch("rready", rready, 1);
            if (arvalid && arready) begin
                exp_addr = cur_row.dram_addr + 32'(ar_num) * cur_row.stride;
                exp_id   = ar_num % `LSU_MAX_OUTST;
                if (araddr !== exp_addr) report_mismatch("araddr", araddr, exp_addr);
                if (arid !== exp_id[`LSU_AXI_ID_W-1:0]) report_mismatch("arid", arid, exp_id);
                if (arlen !== cur_row.len) report_mismatch("arlen", arlen, cur_row.len);
                if (arsize !== 3'd3) report_mismatch("arsize", arsize, 3);
                if (arburst !== 2'b01) report_mismatch("arburst", arburst, 1);
                ar_num++;
            end
            if (rvalid && rready && rlast) rl_num++;
            if (ar_num - rl_num > `LSU_MAX_OUTST) begin
                report_fail($sformatf("%0d bursts outstanding", ar_num - rl_num));
            end
        end
    end

    initial begin
        longint limit_ns;
        limit_ns = MARGIN_NS;
        for (int r = 0; r < NROWS; r++) begin
            limit_ns += longint'(rows[r].len + 1) * rows[r].count * BEAT_NS;
        end
        #(limit_ns);
        $display("watchdog expired after %0d ns, the loads did not complete", limit_ns);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        row_t                      row;
        logic [31:0]               rd;
        logic [31:0]               addr;
        logic [`LSU_SPAD_AW-1:0]   word;
        int                        polls;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        @(posedge clk);
        while (!rst_n) @(posedge clk);

        if (arvalid !== 1'b0) report_mismatch("arvalid", arvalid, 0);
        for (int k = 0; k <= 5; k++) begin
            wb_read(k, rd);
            if (rd !== 32'h0) report_mismatch($sformatf("reg[%0d]", k), rd, 0);
        end
        wb_write(lsu_pkg::REG_DRAM_BASE, 32'hDEAD_BEEF);
        wb_write(lsu_pkg::REG_STRIDE, 32'h1234_5678);
        wb_write(lsu_pkg::REG_SRAM_BASE, 32'h0000_00A5);
        wb_write(lsu_pkg::REG_BURST_CFG, 32'h0000_3C07);
        wb_read(lsu_pkg::REG_DRAM_BASE, rd);
        if (rd !== 32'hDEAD_BEEF) report_mismatch("dram_base", rd, 32'hDEAD_BEEF);
        wb_read(lsu_pkg::REG_STRIDE, rd);
        if (rd !== 32'h1234_5678) report_mismatch("stride", rd, 32'h1234_5678);
        wb_read(lsu_pkg::REG_SRAM_BASE, rd);
        if (rd !== 32'h0000_00A5) report_mismatch("sram_base", rd, 32'hA5);
        wb_read(lsu_pkg::REG_BURST_CFG, rd);
        if (rd !== 32'h0000_3C07) report_mismatch("burst_cfg", rd, 32'h3C07);

        for (int r = 0; r < NROWS; r++) begin
            row = rows[r];
            wb_write(lsu_pkg::REG_DRAM_BASE, row.dram_addr);
            wb_write(lsu_pkg::REG_STRIDE, row.stride);
            wb_write(lsu_pkg::REG_SRAM_BASE, 32'(row.sram_addr));
            wb_write(lsu_pkg::REG_BURST_CFG, {16'd0, row.count, row.len});
            cur_row = row;
            ar_num  = 0;
            rl_num  = 0;
            wb_write(lsu_pkg::REG_CTRL, 32'h1);
            if (row.restart) begin
                wb_read(lsu_pkg::REG_STATUS, rd);
                if (rd[0] !== 1'b1) report_mismatch("status.busy", rd[0], 1);
                wb_write(lsu_pkg::REG_CTRL, 32'h1);
            end
            polls = 0;
            rd    = '0;
            while (rd[1] !== 1'b1 && polls < (row.len + 1) * row.count * 40 + 100) begin
                wb_read(lsu_pkg::REG_STATUS, rd);
                polls++;
            end
            if (rd[1] !== 1'b1) report_fail($sformatf("row %0d never reported done", r));
            if (rd !== {29'd0, row.exp_err, 2'b10}) begin
                report_mismatch("status", rd, {29'd0, row.exp_err, 2'b10});
            end
            if (ar_num != row.count) report_mismatch("ar count", ar_num, row.count);
            if (rl_num != row.count) report_mismatch("rlast count", rl_num, row.count);
            for (int n = 0; n < row.count; n++) begin
                for (int b = 0; b <= row.len; b++) begin
                    addr = row.dram_addr + 32'(n) * row.stride + 32'(b) * 32'd8;
                    word = row.sram_addr + `LSU_SPAD_AW'(n * (row.len + 1) + b);
                    wb_read(win_adr(word, 1'b0), rd);
                    if (rd !== addr) report_mismatch($sformatf("spad[%0h].lo", word), rd, addr);
                    wb_read(win_adr(word, 1'b1), rd);
                    if (rd !== ~addr) report_mismatch($sformatf("spad[%0h].hi", word), rd, ~addr);
                end
            end
        end

        $display("checks finished with %0d errors", err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
